// ==== bench/ps2_device_model.sv ====
// Behavioral PS/2 device for one port, clocks in a host frame and acks, refuses or stays silent
`timescale 1ns/1ps
`default_nettype none

module ps2_device_model (
  input  wire        clk,
  input  wire        ps2_clk,
  input  wire        ps2_dat,
  input  wire  [1:0] mode,
  output logic       clk_pull,
  output logic       dat_pull,
  output logic [7:0] rx_byte,
  output logic       rx_parity,
  output int         frame_count
);

  localparam logic [1:0] MODE_ACCEPT = 2'd0;
  localparam logic [1:0] MODE_SILENT = 2'd2;
  localparam int HALF_PERIOD = 10;    // System cycles per clock phase
  localparam int WAIT_LIMIT  = 1000;

  initial begin
    int         n;
    logic [10:0] bits;
    logic [1:0]  cur_mode;
    clk_pull    = 1'b0;
    dat_pull    = 1'b0;
    rx_byte     = 8'h00;
    rx_parity   = 1'b0;
    frame_count = 0;
    forever begin
      @(posedge clk);
      if (!ps2_clk) begin
        // Host inhibit, wait for the request to send
        n = 0;
        while (!ps2_clk && n < WAIT_LIMIT) begin
          @(posedge clk);
          n++;
        end
        cur_mode = mode;
        if (ps2_clk && !ps2_dat && cur_mode != MODE_SILENT) begin
          repeat (4) @(posedge clk);
          // Start, eight data, parity, stop, then ack in the last clock
          for (int k = 0; k < 11; k++) begin
            clk_pull <= 1'b1;
            bits[k] = ps2_dat;
            if (k == 10) begin
              rx_byte   = bits[8:1];  // Frame complete once the stop bit is in
              rx_parity = bits[9];
              frame_count++;
            end
            if (k == 10 && cur_mode == MODE_ACCEPT) dat_pull <= 1'b1;
            repeat (HALF_PERIOD) @(posedge clk);
            clk_pull <= 1'b0;
            repeat (HALF_PERIOD) @(posedge clk);
          end
          dat_pull <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/ps2_host_array_checker.sv ====
// Concurrent assertions on done, busy and clock inhibit, bound into the PS/2 host array
`timescale 1ns/1ps
`default_nettype none

module ps2_host_array_checker #(
  parameter int  NUM_PORTS      = 2,
  parameter int  INHIBIT_CYCLES = 40,
  localparam int PORT_W         = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input wire                  clk,
  input wire                  reset,
  input wire                  done,
  input wire [PORT_W-1:0]     done_port,
  input wire [NUM_PORTS-1:0]  busy,
  input wire [NUM_PORTS-1:0]  ps2_clk_oe
);

  a_busy_at_done: assert property (@(posedge clk) disable iff (reset)
    done |-> busy[done_port]) else $error("busy low in the done cycle");

  a_busy_after_done: assert property (@(posedge clk) disable iff (reset)
    done |=> !busy[$past(done_port)]) else $error("busy still high after done");

  a_single_done: assert property (@(posedge clk) disable iff (reset)
    done |=> !(done && done_port == $past(done_port))) else $error("done repeated for a port");

  // ------------------------------------------------------------------------
  // Clock inhibit length per lane
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_oe
    logic [15:0] oe_run;  // Consecutive cycles with the clock pulled low

    always_ff @(posedge clk) begin
      if (reset)              oe_run <= '0;
      else if (ps2_clk_oe[i]) oe_run <= oe_run + 16'd1;
      else                    oe_run <= '0;
    end

    a_inhibit_len: assert property (@(posedge clk) disable iff (reset)
      int'(oe_run) <= INHIBIT_CYCLES) else $error("clock inhibit held too long");
  end

endmodule

bind ps2_host_array ps2_host_array_checker #(
  .NUM_PORTS     (NUM_PORTS),
  .INHIBIT_CYCLES(INHIBIT_CYCLES)
) u_checker (
  .clk       (clk),
  .reset     (reset),
  .done      (done),
  .done_port (done_port),
  .busy      (busy),
  .ps2_clk_oe(ps2_clk_oe)
);

`default_nettype wire

// ==== bench/ps2_host_array_tb.sv ====
// Testbench for the PS/2 host array, drives commands against device models and checks results
`timescale 1ns/1ps
`default_nettype none

module ps2_host_array_tb import ps2_pkg::*; ;

  localparam int NUM_PORTS  = 2;
  localparam int PORT_W     = 1;
  localparam int WAIT_LIMIT = 2000;
  localparam logic [1:0] MODE_ACCEPT = 2'd0;
  localparam logic [1:0] MODE_REFUSE = 2'd1;
  localparam logic [1:0] MODE_SILENT = 2'd2;

  logic                 clk;
  logic                 reset;
  logic                 cmd_strobe;
  logic [PORT_W-1:0]    cmd_port;
  logic [7:0]           cmd_byte;
  logic [NUM_PORTS-1:0] busy;
  logic                 done;
  logic [PORT_W-1:0]    done_port;
  cmd_status_t          done_status;
  logic [NUM_PORTS-1:0] clk_line;
  logic [NUM_PORTS-1:0] dat_line;
  logic [NUM_PORTS-1:0] ps2_clk_oe;
  logic [NUM_PORTS-1:0] ps2_dat_oe;
  logic [NUM_PORTS-1:0] dev_clk_pull;
  logic [NUM_PORTS-1:0] dev_dat_pull;
  logic [1:0]           port_mode [NUM_PORTS];
  logic [7:0]           rx_byte [NUM_PORTS];
  logic                 rx_parity [NUM_PORTS];
  int                   frame_count [NUM_PORTS];
  logic [7:0]           exp_byte [NUM_PORTS];
  logic [1:0]           exp_mode [NUM_PORTS];
  int                   issued_count [NUM_PORTS];
  int                   done_count [NUM_PORTS];
  int                   checks;
  int                   cmp_errors;
  int                   flow_errors;
  int                   seed;

  always #10 clk = ~clk;

  ps2_host_array #(
    .NUM_PORTS(NUM_PORTS), .INHIBIT_CYCLES(40),
    .START_TIMEOUT_CYCLES(400), .XFER_TIMEOUT_CYCLES(600)
  ) dut (
    .clk, .reset, .cmd_strobe, .cmd_port, .cmd_byte, .busy, .done, .done_port,
    .done_status, .ps2_clk_in(clk_line), .ps2_dat_in(dat_line), .ps2_clk_oe, .ps2_dat_oe
  );

  // Open-drain lines resolved as wired-AND
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_dev
    assign clk_line[i] = ~(ps2_clk_oe[i] | dev_clk_pull[i]);
    assign dat_line[i] = ~(ps2_dat_oe[i] | dev_dat_pull[i]);
    ps2_device_model u_dev (
      .clk, .ps2_clk(clk_line[i]), .ps2_dat(dat_line[i]), .mode(port_mode[i]),
      .clk_pull(dev_clk_pull[i]), .dat_pull(dev_dat_pull[i]), .rx_byte(rx_byte[i]),
      .rx_parity(rx_parity[i]), .frame_count(frame_count[i])
    );
  end

  function automatic cmd_status_t expected_status(input logic [1:0] mode);
    case (mode)
      MODE_ACCEPT: return STATUS_SENT;
      MODE_REFUSE: return STATUS_NACK;
      default:     return STATUS_TIMEOUT;
    endcase
  endfunction

  function automatic logic [8:0] parity_frame(input logic [7:0] b);
    int   ones;
    logic par;
    ones = 0;
    for (int i = 0; i < 8; i++) ones += b[i];
    par = (ones % 2 == 0);  // Total count of ones comes out odd
    return {par, b};
  endfunction

  // ------------------------------------------------------------------------
  // Result comparison
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    if (!reset && done) begin
      checks++;
      assert (issued_count[done_port] != done_count[done_port]) else begin
        cmp_errors++;
        $display("Done reported on port %0d with no command in flight", done_port);
      end
      assert (done_status == expected_status(exp_mode[done_port])) else begin
        cmp_errors++;
        $display("FAILED %0t: port %0d status %0d, expected %0d", $time, done_port,
                 done_status, expected_status(exp_mode[done_port]));
      end
      if (exp_mode[done_port] != MODE_SILENT) begin
        assert ({rx_parity[done_port], rx_byte[done_port]} ==
                parity_frame(exp_byte[done_port])) else begin
          cmp_errors++;
          $display("FAILED %0t: port %0d frame %h, expected %h", $time, done_port,
                   {rx_parity[done_port], rx_byte[done_port]},
                   parity_frame(exp_byte[done_port]));
        end
      end
      done_count[done_port]++;
    end
  end

  task automatic strobe_cmd(input int p, input logic [7:0] b, input logic [1:0] m,
                            input bit expect_accept);
    @(posedge clk);
    cmd_strobe <= 1'b1;
    cmd_port   <= PORT_W'(p);
    cmd_byte   <= b;
    if (expect_accept) begin
      port_mode[p] <= m;
      exp_byte[p] = b;
      exp_mode[p] = m;
      issued_count[p]++;
    end
  endtask

  task automatic end_strobe();
    @(posedge clk);
    cmd_strobe <= 1'b0;
  endtask

  task automatic wait_idle(input int p);
    int n;
    n = 0;
    while ((issued_count[p] != done_count[p] || busy[p]) && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (n >= WAIT_LIMIT) begin
      flow_errors++;
      $display("Port %0d never finished its command", p);
    end
  endtask

  initial begin
    int          p;
    int          frames_before;
    int          dones_before;
    logic [1:0]  m;
    logic [7:0]  b;
    clk = 1'b0;
    reset = 1'b1;
    cmd_strobe = 1'b0;
    cmd_port = '0;
    cmd_byte = 8'h00;
    seed = 56157;
    checks = 0;
    cmp_errors = 0;
    flow_errors = 0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      port_mode[i] = MODE_ACCEPT;
      exp_mode[i] = MODE_ACCEPT;
      exp_byte[i] = 8'h00;
      issued_count[i] = 0;
      done_count[i] = 0;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    strobe_cmd(0, 8'hED, MODE_ACCEPT, 1'b1);  // Single accepted command
    end_strobe();
    wait_idle(0);

    strobe_cmd(0, 8'hF4, MODE_ACCEPT, 1'b1);  // Both lanes in flight
    strobe_cmd(1, 8'h3C, MODE_ACCEPT, 1'b1);
    end_strobe();
    wait_idle(0);
    wait_idle(1);

    strobe_cmd(1, 8'hFF, MODE_REFUSE, 1'b1);
    end_strobe();
    wait_idle(1);

    strobe_cmd(0, 8'h20, MODE_SILENT, 1'b1);
    end_strobe();
    wait_idle(0);

    // Second strobe lands while port 0 is busy
    frames_before = frame_count[0];
    dones_before = done_count[0];
    strobe_cmd(0, 8'hA5, MODE_ACCEPT, 1'b1);
    strobe_cmd(0, 8'h5A, MODE_ACCEPT, 1'b0);
    end_strobe();
    wait_idle(0);
    repeat (50) @(posedge clk);
    assert (frame_count[0] == frames_before + 1 && done_count[0] == dones_before + 1)
      else begin
        flow_errors++;
        $display("FAILED %0t: dropped strobe produced frames %0d dones %0d", $time,
                 frame_count[0] - frames_before, done_count[0] - dones_before);
      end

    for (int k = 0; k < 20; k++) begin
      p = $random(seed) & 1;
      m = 2'($unsigned($random(seed)) % 3);
      b = 8'($random(seed));
      wait_idle(p);
      strobe_cmd(p, b, m, 1'b1);
      end_strobe();
    end
    wait_idle(0);
    wait_idle(1);

    $display("Checks %0d, compare errors %0d, flow errors %0d", checks, cmp_errors,
             flow_errors);
    if (cmp_errors == 0 && flow_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/ps2_pkg.sv
logic/ps2_edge_detect.sv
logic/ps2_cmdout.sv
logic/ps2_cmd_dispatch.sv
logic/ps2_result_collect.sv
logic/ps2_host_array.sv
bench/ps2_device_model.sv
bench/ps2_host_array_checker.sv
bench/ps2_host_array_tb.sv

// ==== logic/ps2_cmd_dispatch.sv ====
// Command dispatcher that takes one strobed command and raises the target port's request
`timescale 1ns/1ps
`default_nettype none

module ps2_cmd_dispatch #(
  parameter int  NUM_PORTS = 2,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        cmd_strobe,
  input  wire  [PORT_W-1:0]          cmd_port,
  input  wire  [7:0]                 cmd_byte,
  input  wire  [NUM_PORTS-1:0]       port_release,
  output logic [NUM_PORTS-1:0]       send_command,
  output logic [NUM_PORTS-1:0][7:0]  cmd_bytes,
  output logic [NUM_PORTS-1:0]       busy
);

  logic port_idle;
  logic accept;

  // Out-of-range ports are never idle
  assign port_idle = (int'(cmd_port) < NUM_PORTS) ? ~send_command[cmd_port] : 1'b0;
  assign accept    = cmd_strobe & port_idle;

  always_ff @(posedge clk) begin
    if (reset) begin
      send_command <= '0;
    end else begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (port_release[i])
          send_command[i] <= 1'b0;
        else if (accept && int'(cmd_port) == i)
          send_command[i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) cmd_bytes[cmd_port] <= cmd_byte;  // Held until release
  end

  assign busy = send_command;

endmodule

`default_nettype wire

// ==== logic/ps2_cmdout.sv ====
// Host-to-device PS/2 transmitter for one port, with inhibit, start and transfer timeouts
`timescale 1ns/1ps
`default_nettype none

module ps2_cmdout import ps2_pkg::*; #(
  parameter int INHIBIT_CYCLES       = DEFAULT_INHIBIT_CYCLES,
  parameter int START_TIMEOUT_CYCLES = DEFAULT_START_TIMEOUT_CYCLES,
  parameter int XFER_TIMEOUT_CYCLES  = DEFAULT_XFER_TIMEOUT_CYCLES
) (
  input  wire        clk,
  input  wire        reset,
  input  wire  [7:0] cmd_byte,
  input  wire        send_command,
  input  wire        clk_posedge,
  input  wire        clk_negedge,
  input  wire        dat_sync,
  output logic       ps2_clk_oe,
  output logic       ps2_dat_oe,
  output logic       command_was_sent,
  output logic       error_timed_out,
  output logic       ack_nack
);

  localparam int INHIBIT_W = $clog2(INHIBIT_CYCLES + 1);
  localparam int START_W   = $clog2(START_TIMEOUT_CYCLES + 1);
  localparam int XFER_W    = $clog2(XFER_TIMEOUT_CYCLES + 1);

  localparam logic [INHIBIT_W-1:0] INHIBIT_LAST = INHIBIT_W'(INHIBIT_CYCLES - 1);
  localparam logic [INHIBIT_W-1:0] INHIBIT_HALF = INHIBIT_W'(INHIBIT_CYCLES / 2);
  localparam logic [START_W-1:0]   START_LIMIT  = START_W'(START_TIMEOUT_CYCLES);
  localparam logic [XFER_W-1:0]    XFER_LIMIT   = XFER_W'(XFER_TIMEOUT_CYCLES);

  tx_state_t            state;
  tx_state_t            state_next;
  logic [8:0]           frame;           // Parity then byte, LSB first
  logic [3:0]           cur_bit;
  logic [INHIBIT_W-1:0] inhibit_count;
  logic [START_W-1:0]   start_count;
  logic [XFER_W-1:0]    xfer_count;
  logic                 in_xfer;

  assign in_xfer = (state == TRANSMIT_DATA) || (state == TRANSMIT_STOP) ||
                   (state == RECEIVE_ACK);

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) state <= IDLE;
    else       state <= state_next;
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:          if (send_command) state_next = INHIBIT;
      INHIBIT:       if (inhibit_count == INHIBIT_LAST) state_next = WAIT_CLOCK;
      WAIT_CLOCK: begin
        if (clk_negedge)                     state_next = TRANSMIT_DATA;
        else if (start_count == START_LIMIT) state_next = TIMED_OUT;
      end
      TRANSMIT_DATA: begin
        if (clk_negedge && cur_bit == 4'd8) state_next = TRANSMIT_STOP;
        else if (xfer_count == XFER_LIMIT)  state_next = TIMED_OUT;
      end
      TRANSMIT_STOP: begin
        if (clk_negedge)                   state_next = RECEIVE_ACK;
        else if (xfer_count == XFER_LIMIT) state_next = TIMED_OUT;
      end
      RECEIVE_ACK: begin
        if (clk_posedge)                   state_next = SENT;
        else if (xfer_count == XFER_LIMIT) state_next = TIMED_OUT;
      end
      SENT, TIMED_OUT: if (!send_command) state_next = IDLE;
      default:       state_next = IDLE;
    endcase
  end

  // ------------------------------------------------------------------------
  // Counters and shift position
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      inhibit_count <= '0;
      start_count   <= '0;
      xfer_count    <= '0;
      cur_bit       <= '0;
    end else begin
      if (state != INHIBIT)             inhibit_count <= '0;
      else if (inhibit_count != INHIBIT_LAST) inhibit_count <= inhibit_count + 1'b1;

      if (state != WAIT_CLOCK)          start_count <= '0;
      else if (start_count != START_LIMIT) start_count <= start_count + 1'b1;

      if (!in_xfer)                     xfer_count <= '0;
      else if (xfer_count != XFER_LIMIT) xfer_count <= xfer_count + 1'b1;

      if (state != TRANSMIT_DATA)       cur_bit <= '0;
      else if (clk_negedge)             cur_bit <= cur_bit + 4'd1;
    end
  end

  // Byte and odd parity captured while idle
  always_ff @(posedge clk) begin
    if (state == IDLE) frame <= {~^cmd_byte, cmd_byte};
  end

  // ------------------------------------------------------------------------
  // Completion flags and acknowledge
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      command_was_sent <= 1'b0;
      error_timed_out  <= 1'b0;
      ack_nack         <= 1'b0;
    end else begin
      if (state == SENT)                         command_was_sent <= 1'b1;
      else if (!send_command || state == IDLE)   command_was_sent <= 1'b0;

      if (state == TIMED_OUT)                    error_timed_out <= 1'b1;
      else if (!send_command || state == IDLE)   error_timed_out <= 1'b0;

      // Assume refused until the device pulls data low in the ack clock
      if (state == TRANSMIT_STOP)                ack_nack <= 1'b1;
      else if (state == RECEIVE_ACK && !dat_sync) ack_nack <= 1'b0;
    end
  end

  // Pull-low enables for the open-drain lines
  always_comb begin
    ps2_clk_oe = (state == INHIBIT);
    case (state)
      INHIBIT:       ps2_dat_oe = (inhibit_count >= INHIBIT_HALF);  // Start bit
      WAIT_CLOCK:    ps2_dat_oe = 1'b1;
      TRANSMIT_DATA: ps2_dat_oe = ~frame[cur_bit];
      default:       ps2_dat_oe = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/ps2_edge_detect.sv ====
// Per-port synchronizer for PS/2 clock and data, giving one-cycle clock edge pulses to a lane
`timescale 1ns/1ps
`default_nettype none

module ps2_edge_detect (
  input  wire  clk,
  input  wire  reset,
  input  wire  ps2_clk_in,
  input  wire  ps2_dat_in,
  output logic clk_posedge,
  output logic clk_negedge,
  output logic dat_sync
);

  logic clk_meta;
  logic clk_sync;
  logic clk_prev;
  logic dat_meta;

  // Lines idle high, so reset to 1 to avoid a false edge
  always_ff @(posedge clk) begin
    if (reset) begin
      clk_meta <= 1'b1;
      clk_sync <= 1'b1;
      clk_prev <= 1'b1;
      dat_meta <= 1'b1;
      dat_sync <= 1'b1;
    end else begin
      clk_meta <= ps2_clk_in;
      clk_sync <= clk_meta;
      clk_prev <= clk_sync;
      dat_meta <= ps2_dat_in;
      dat_sync <= dat_meta;
    end
  end

  assign clk_posedge = clk_sync & ~clk_prev;  // Two cycles behind the pin
  assign clk_negedge = ~clk_sync & clk_prev;

endmodule

`default_nettype wire

// ==== logic/ps2_host_array.sv ====
// Top level of the multi-port PS/2 command transmitter: dispatcher, per-port lanes, collector
`timescale 1ns/1ps
`default_nettype none

module ps2_host_array import ps2_pkg::*; #(
  parameter int  NUM_PORTS            = 2,
  parameter int  INHIBIT_CYCLES       = DEFAULT_INHIBIT_CYCLES,
  parameter int  START_TIMEOUT_CYCLES = DEFAULT_START_TIMEOUT_CYCLES,
  parameter int  XFER_TIMEOUT_CYCLES  = DEFAULT_XFER_TIMEOUT_CYCLES,
  localparam int PORT_W               = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   cmd_strobe,
  input  wire  [PORT_W-1:0]     cmd_port,
  input  wire  [7:0]            cmd_byte,
  output logic [NUM_PORTS-1:0]  busy,
  output logic                  done,
  output logic [PORT_W-1:0]     done_port,
  output cmd_status_t           done_status,
  input  wire  [NUM_PORTS-1:0]  ps2_clk_in,
  input  wire  [NUM_PORTS-1:0]  ps2_dat_in,
  output logic [NUM_PORTS-1:0]  ps2_clk_oe,
  output logic [NUM_PORTS-1:0]  ps2_dat_oe
);

  logic [NUM_PORTS-1:0]      send_command;
  logic [NUM_PORTS-1:0][7:0] cmd_bytes;
  logic [NUM_PORTS-1:0]      port_release;
  logic [NUM_PORTS-1:0]      clk_posedge;
  logic [NUM_PORTS-1:0]      clk_negedge;
  logic [NUM_PORTS-1:0]      dat_sync;
  logic [NUM_PORTS-1:0]      command_was_sent;
  logic [NUM_PORTS-1:0]      error_timed_out;
  logic [NUM_PORTS-1:0]      ack_nack;

  ps2_cmd_dispatch #(.NUM_PORTS(NUM_PORTS)) u_dispatch (
    .clk, .reset, .cmd_strobe, .cmd_port, .cmd_byte,
    .port_release, .send_command, .cmd_bytes, .busy
  );

  // ------------------------------------------------------------------------
  // One lane per port
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_lane
    ps2_edge_detect u_edge (
      .clk, .reset,
      .ps2_clk_in (ps2_clk_in[i]),
      .ps2_dat_in (ps2_dat_in[i]),
      .clk_posedge(clk_posedge[i]),
      .clk_negedge(clk_negedge[i]),
      .dat_sync   (dat_sync[i])
    );

    ps2_cmdout #(
      .INHIBIT_CYCLES      (INHIBIT_CYCLES),
      .START_TIMEOUT_CYCLES(START_TIMEOUT_CYCLES),
      .XFER_TIMEOUT_CYCLES (XFER_TIMEOUT_CYCLES)
    ) u_cmdout (
      .clk, .reset,
      .cmd_byte        (cmd_bytes[i]),
      .send_command    (send_command[i]),
      .clk_posedge     (clk_posedge[i]),
      .clk_negedge     (clk_negedge[i]),
      .dat_sync        (dat_sync[i]),
      .ps2_clk_oe      (ps2_clk_oe[i]),
      .ps2_dat_oe      (ps2_dat_oe[i]),
      .command_was_sent(command_was_sent[i]),
      .error_timed_out (error_timed_out[i]),
      .ack_nack        (ack_nack[i])
    );
  end

  ps2_result_collect #(.NUM_PORTS(NUM_PORTS)) u_collect (
    .clk, .reset, .command_was_sent, .error_timed_out, .ack_nack,
    .port_release, .done, .done_port, .done_status
  );

endmodule

`default_nettype wire

// ==== logic/ps2_pkg.sv ====
// Shared PS/2 host transmitter types and default timing, imported by the RTL and the bench
`default_nettype none

package ps2_pkg;

  // ------------------------------------------------------------------------
  // Transmitter FSM states
  // ------------------------------------------------------------------------
  typedef enum logic [2:0] {
    IDLE          = 3'd0,
    INHIBIT       = 3'd1,   // Clock held low by host
    WAIT_CLOCK    = 3'd2,   // Request to send, waiting for device clock
    TRANSMIT_DATA = 3'd3,   // Eight data bits then parity
    TRANSMIT_STOP = 3'd4,   // Data released for stop bit
    RECEIVE_ACK   = 3'd5,
    SENT          = 3'd6,
    TIMED_OUT     = 3'd7
  } tx_state_t;

  // Outcome reported per command
  typedef enum logic [1:0] {
    STATUS_SENT    = 2'd0,
    STATUS_NACK    = 2'd1,
    STATUS_TIMEOUT = 2'd2
  } cmd_status_t;

  // Timing at a 12.5 MHz system clock
  localparam int DEFAULT_INHIBIT_CYCLES       = 1262;    // About 100 us
  localparam int DEFAULT_START_TIMEOUT_CYCLES = 187500;  // 15 ms
  localparam int DEFAULT_XFER_TIMEOUT_CYCLES  = 25000;   // 2 ms

endpackage

`default_nettype wire

// ==== logic/ps2_result_collect.sv ====
// Result collector that reports finished lanes one at a time and releases their requests
`timescale 1ns/1ps
`default_nettype none

module ps2_result_collect import ps2_pkg::*; #(
  parameter int  NUM_PORTS = 2,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire  [NUM_PORTS-1:0]  command_was_sent,
  input  wire  [NUM_PORTS-1:0]  error_timed_out,
  input  wire  [NUM_PORTS-1:0]  ack_nack,
  output logic [NUM_PORTS-1:0]  port_release,
  output logic                  done,
  output logic [PORT_W-1:0]     done_port,
  output cmd_status_t           done_status
);

  logic [NUM_PORTS-1:0] finished;
  logic [NUM_PORTS-1:0] reported;   // Flags still high after their report
  logic [NUM_PORTS-1:0] pending;
  logic [NUM_PORTS-1:0] pick_mask;
  logic [PORT_W-1:0]    pick;
  logic                 found;
  cmd_status_t          pick_status;

  assign finished = command_was_sent | error_timed_out;
  assign pending  = finished & ~reported;

  // Lowest pending index wins
  always_comb begin
    found = 1'b0;
    pick  = '0;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      if (pending[i]) begin
        found = 1'b1;
        pick  = PORT_W'(i);
      end
    end
    pick_mask       = '0;
    pick_mask[pick] = found;

    if (error_timed_out[pick]) pick_status = STATUS_TIMEOUT;
    else if (ack_nack[pick])   pick_status = STATUS_NACK;
    else                       pick_status = STATUS_SENT;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done         <= 1'b0;
      port_release <= '0;
      reported     <= '0;
    end else begin
      done         <= found;
      port_release <= pick_mask;
      reported     <= (reported & finished) | pick_mask;  // Bit drops once flags clear
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      done_port   <= pick;
      done_status <= pick_status;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PS/2 host array testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module ps2_host_array_tb \
  -o ps2_tb_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/ps2_tb_sim > sim.log 2>&1
cat sim.log

grep -q "TB PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
